// File: compile.f
+incdir+verif
hw/rv_pkg.sv
hw/ctrl_if.sv
hw/maindec.sv
hw/controller.sv
hw/regfile.sv
hw/alu.sv
hw/datapath.sv
hw/dmem.sv
hw/rv_core.sv
verif/tb_rv_core.sv

// File: hw/alu.sv
// ----------------------------------------------------------
// ALU with the ten RV32I functions, pass-B and compare flags
// ----------------------------------------------------------
`timescale 1ns/1ns
module alu (
    input  logic [rv_pkg::XLEN-1:0] i_a,
    input  logic [rv_pkg::XLEN-1:0] i_b,
    input  logic [3:0]              i_ctrl, // ALU function
    output logic [rv_pkg::XLEN-1:0] o_y,
    output logic                    o_zero, // Result is zero
    output logic                    o_lt    // a < b, sign per function
);
    import rv_pkg::*;

    logic       slt;   // Signed compare
    logic       sltu;  // Unsigned compare
    logic [4:0] shamt;

    assign slt   = ($signed(i_a) < $signed(i_b));
    assign sltu  = (i_a < i_b);
    assign shamt = i_b[4:0];

    always_comb begin
        case (i_ctrl)
            ALU_ADD:   o_y = i_a + i_b;
            ALU_SUB:   o_y = i_a - i_b;
            ALU_AND:   o_y = i_a & i_b;
            ALU_OR:    o_y = i_a | i_b;
            ALU_XOR:   o_y = i_a ^ i_b;
            ALU_SLT:   o_y = {{(XLEN-1){1'b0}}, slt};
            ALU_SLTU:  o_y = {{(XLEN-1){1'b0}}, sltu};
            ALU_SLL:   o_y = i_a << shamt;
            ALU_SRL:   o_y = i_a >> shamt;
            ALU_SRA:   o_y = $signed(i_a) >>> shamt;
            ALU_PASSB: o_y = i_b;              // lui
            default:   o_y = '0;
        endcase
    end

    assign o_zero = (o_y == '0);
    assign o_lt   = (i_ctrl == ALU_SLTU) ? sltu : slt; // Unsigned for bltu/bgeu

endmodule

// File: hw/controller.sv
// ----------------------------------------------------------
// Controller with main decode, ALU decode and branch choice
// ----------------------------------------------------------
`timescale 1ns/1ns
module controller (
    input  rv_pkg::instr_u i_instr,    // Current instruction
    ctrl_if.ctrl           cif,        // Controls out, flags in
    output logic           o_memwrite, // Store enable to dmem
    output logic [2:0]     o_f3        // Access size to dmem
);
    import rv_pkg::*;

    logic       branch;
    logic       jump;
    logic       brcond;   // Branch condition met
    logic [1:0] aluop;
    logic [2:0] funct3;
    logic       f7b5;     // Selects sub and sra
    logic       is_rtype;

    maindec u_maindec (
        .i_op        (i_instr.r.op),
        .i_funct3    (i_instr.r.funct3),
        .o_resultsrc (cif.resultsrc),
        .o_memwrite  (o_memwrite),
        .o_branch    (branch),
        .o_alusrc    (cif.alusrc),
        .o_regwrite  (cif.regwrite),
        .o_jump      (jump),
        .o_immsrc    (cif.immsrc),
        .o_aluop     (aluop),
        .o_f3        (o_f3)
    );

    assign funct3   = i_instr.r.funct3;
    assign f7b5     = i_instr.r.funct7[5];
    assign is_rtype = (i_instr.r.op == OP_RTYPE); // No subi in I-type

    always_comb begin
        case (aluop)
            ALUOP_BRANCH: cif.alucontrol = funct3[1] ? ALU_SLTU : ALU_SUB; // bltu/bgeu unsigned
            ALUOP_FUNC: begin
                case (funct3)
                    3'b000:  cif.alucontrol = (is_rtype && f7b5) ? ALU_SUB : ALU_ADD;
                    3'b001:  cif.alucontrol = ALU_SLL;
                    3'b010:  cif.alucontrol = ALU_SLT;
                    3'b011:  cif.alucontrol = ALU_SLTU;
                    3'b100:  cif.alucontrol = ALU_XOR;
                    3'b101:  cif.alucontrol = f7b5 ? ALU_SRA : ALU_SRL; // srai too
                    3'b110:  cif.alucontrol = ALU_OR;
                    default: cif.alucontrol = ALU_AND;
                endcase
            end
            default: cif.alucontrol = (i_instr.r.op == OP_LUI) ? ALU_PASSB : ALU_ADD;
        endcase
    end

    // beq/bne use zero and the rest use lt with funct3[0] inverting
    assign brcond    = (funct3[2] ? cif.lt : cif.zero) ^ funct3[0];
    assign cif.pcsrc = jump | (branch & brcond);

    // Redirect only from branch or jal opcodes
    always_comb begin
        assert final (!cif.pcsrc || i_instr.r.op == OP_BRANCH || i_instr.r.op == OP_JAL)
            else $error("controller: pcsrc set for op %b", i_instr.r.op);
    end

endmodule

// File: hw/ctrl_if.sv
// ----------------------------------------------------------
// Control and flag bundle between controller and datapath
// ----------------------------------------------------------
`timescale 1ns/1ns
interface ctrl_if;

    logic       regwrite;   // Register file write enable
    logic       alusrc;     // ALU B from immediate
    logic [2:0] immsrc;     // Immediate format
    logic [1:0] resultsrc;  // Write-back source
    logic [3:0] alucontrol; // ALU function
    logic       pcsrc;      // Take branch/jump target
    logic       zero;       // ALU result is zero
    logic       lt;         // Less-than, sign set by ALU function

    modport ctrl (
        output regwrite, alusrc, immsrc, resultsrc, alucontrol, pcsrc,
        input  zero, lt
    );

    modport dp (
        input  regwrite, alusrc, immsrc, resultsrc, alucontrol, pcsrc,
        output zero, lt
    );

endinterface

// File: hw/datapath.sv
// ----------------------------------------------------------
// Datapath with PC, immediate extend, register file and ALU
// Steered by the controller through ctrl_if
// ----------------------------------------------------------
`timescale 1ns/1ns
module datapath (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  rv_pkg::instr_u          i_instr, // Current instruction
    ctrl_if.dp                      cif,     // Controls in, flags out
    input  logic [rv_pkg::XLEN-1:0] i_rdata, // Extended load data
    output logic [rv_pkg::XLEN-1:0] o_pc,    // Fetch address
    output logic [rv_pkg::XLEN-1:0] o_addr,  // Data address
    output logic [rv_pkg::XLEN-1:0] o_wdata  // Store data, unshifted
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_target;
    logic [XLEN-1:0] immext;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] srcb;
    logic [XLEN-1:0] aluy;
    logic [XLEN-1:0] result;

    assign pc_plus4  = o_pc + 32'd4;
    assign pc_target = o_pc + immext;       // Branch and jal target

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc <= '0;
        end else begin
            o_pc <= cif.pcsrc ? pc_target : pc_plus4;
        end
    end

    // Immediate pieces from the format views
    always_comb begin
        case (cif.immsrc)
            IMM_S: immext = {{20{i_instr.s.imm11_5[6]}}, i_instr.s.imm11_5, i_instr.s.imm4_0};
            IMM_B: immext = {{20{i_instr.b.imm12}}, i_instr.b.imm11, i_instr.b.imm10_5,
                             i_instr.b.imm4_1, 1'b0};
            IMM_J: immext = {{12{i_instr.j.imm20}}, i_instr.j.imm19_12, i_instr.j.imm11,
                             i_instr.j.imm10_1, 1'b0};
            IMM_U: immext = {i_instr.u.imm31_12, 12'b0};
            default: immext = {{20{i_instr.i.imm11_0[11]}}, i_instr.i.imm11_0};
        endcase
    end

    regfile u_regfile (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_we  (cif.regwrite),
        .i_ra1 (i_instr.r.rs1),
        .i_ra2 (i_instr.r.rs2),
        .i_wa  (i_instr.r.rd),
        .i_wd  (result),
        .o_rd1 (rd1),
        .o_rd2 (rd2)
    );

    assign srcb = cif.alusrc ? immext : rd2;

    alu u_alu (
        .i_a    (rd1),
        .i_b    (srcb),
        .i_ctrl (cif.alucontrol),
        .o_y    (aluy),
        .o_zero (cif.zero),
        .o_lt   (cif.lt)
    );

    always_comb begin
        case (cif.resultsrc)
            RES_MEM: result = i_rdata;
            RES_PC4: result = pc_plus4;     // jal link
            default: result = aluy;
        endcase
    end

    assign o_addr  = aluy;
    assign o_wdata = rd2;

endmodule

// File: hw/dmem.sv
// ----------------------------------------------------------
// Data memory of 256 words with byte lanes and funct3 sizing
// ----------------------------------------------------------
`timescale 1ns/1ns
module dmem (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_we,         // Store enable
    input  logic [2:0]              i_f3,         // Access size and sign
    input  logic [rv_pkg::XLEN-1:0] i_addr,       // Byte address
    input  logic [rv_pkg::XLEN-1:0] i_wdata,      // Store data, low aligned
    output logic [rv_pkg::XLEN-1:0] o_rdata,      // Extended load data
    output logic [3:0]              o_be,         // Byte enables
    output logic [rv_pkg::XLEN-1:0] o_wdata_lane  // Store data in its lanes
);
    import rv_pkg::*;

    logic [XLEN-1:0] mem [256];
    logic [7:0]      widx;       // Word index
    logic [XLEN-1:0] rword_sh;   // Read word shifted down to the access

    assign widx = i_addr[9:2];

    always_comb begin
        case (i_f3[1:0])
            2'b00:   o_be = 4'b0001 << i_addr[1:0];
            2'b01:   o_be = 4'b0011 << {i_addr[1], 1'b0};
            default: o_be = 4'b1111;
        endcase
    end

    assign o_wdata_lane = (i_f3 == F3_SW) ? i_wdata : i_wdata << {i_addr[1:0], 3'b000};

    always_ff @(posedge i_clk) begin
        if (i_we && !i_rst) begin
            for (int b = 0; b < 4; b++) begin
                if (o_be[b]) mem[widx][8*b +: 8] <= o_wdata_lane[8*b +: 8];
            end
        end
    end

    assign rword_sh = mem[widx] >> {i_addr[1:0], 3'b000};

    always_comb begin
        case (i_f3)
            3'b000:  o_rdata = {{24{rword_sh[7]}}, rword_sh[7:0]};   // lb
            3'b001:  o_rdata = {{16{rword_sh[15]}}, rword_sh[15:0]}; // lh
            3'b100:  o_rdata = {24'b0, rword_sh[7:0]};               // lbu
            3'b101:  o_rdata = {16'b0, rword_sh[15:0]};              // lhu
            default: o_rdata = mem[widx];
        endcase
    end

    // lh/lhu/sh carry the halfword size and must be aligned
    a_half_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_f3[1:0] == 2'b01) |-> !i_addr[0])
        else $error("dmem: misaligned halfword at %h", i_addr);

endmodule

// File: hw/maindec.sv
// ----------------------------------------------------------
// Main decoder from opcode to primary datapath controls
// Instantiated by the controller
// ----------------------------------------------------------
`timescale 1ns/1ns
module maindec (
    input  logic [6:0] i_op,        // Opcode field
    input  logic [2:0] i_funct3,    // Access size for loads/stores
    output logic [1:0] o_resultsrc, // Write-back source
    output logic       o_memwrite,  // Store enable
    output logic       o_branch,    // Conditional branch
    output logic       o_alusrc,    // ALU B from immediate
    output logic       o_regwrite,  // Register write enable
    output logic       o_jump,      // Unconditional jump
    output logic [2:0] o_immsrc,    // Immediate format
    output logic [1:0] o_aluop,     // ALU operation class
    output logic [2:0] o_f3         // Memory access size
);
    import rv_pkg::*;

    always_comb begin
        o_regwrite  = 1'b0;                 // Unknown opcodes keep these
        o_immsrc    = IMM_I;
        o_alusrc    = 1'b0;
        o_memwrite  = 1'b0;
        o_resultsrc = RES_ALU;
        o_branch    = 1'b0;
        o_aluop     = ALUOP_ADD;
        o_jump      = 1'b0;
        o_f3        = F3_SW;                // Word unless load/store says otherwise

        case (i_op)
            OP_LOAD: begin
                o_regwrite  = 1'b1;
                o_alusrc    = 1'b1;         // rs1 + imm
                o_resultsrc = RES_MEM;
                o_f3        = i_funct3;
            end
            OP_STORE: begin
                o_immsrc    = IMM_S;
                o_alusrc    = 1'b1;
                o_memwrite  = 1'b1;
                o_f3        = i_funct3;
            end
            OP_RTYPE: begin
                o_regwrite  = 1'b1;
                o_aluop     = ALUOP_FUNC;
            end
            OP_ITYPE: begin
                o_regwrite  = 1'b1;
                o_alusrc    = 1'b1;
                o_aluop     = ALUOP_FUNC;
            end
            OP_BRANCH: begin
                o_immsrc    = IMM_B;
                o_branch    = 1'b1;
                o_aluop     = ALUOP_BRANCH; // Compare rs1 with rs2
            end
            OP_JAL: begin
                o_regwrite  = 1'b1;
                o_immsrc    = IMM_J;
                o_resultsrc = RES_PC4;      // Link value
                o_jump      = 1'b1;
            end
            OP_LUI: begin
                o_regwrite  = 1'b1;
                o_immsrc    = IMM_U;
                o_alusrc    = 1'b1;         // Passed through the ALU
            end
            default: begin
            end
        endcase
    end

    // A store never writes back
    always_comb begin
        assert final (!(o_memwrite && o_regwrite))
            else $error("maindec: memwrite and regwrite both set, op %b", i_op);
    end

endmodule

// File: hw/regfile.sv
// ----------------------------------------------------------
// 32 x 32 register file with two reads and one write
// ----------------------------------------------------------
`timescale 1ns/1ns
module regfile (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_we,  // Write enable
    input  logic [4:0]              i_ra1, // Read address 1
    input  logic [4:0]              i_ra2, // Read address 2
    input  logic [4:0]              i_wa,  // Write address
    input  logic [rv_pkg::XLEN-1:0] i_wd,  // Write data
    output logic [rv_pkg::XLEN-1:0] o_rd1,
    output logic [rv_pkg::XLEN-1:0] o_rd2
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge i_clk) begin
        if (i_we && !i_rst) begin       // No writes while in reset
            regs[i_wa] <= i_wd;
        end
    end

    // x0 reads zero whatever was written there
    assign o_rd1 = (i_ra1 == 5'd0) ? '0 : regs[i_ra1];
    assign o_rd2 = (i_ra2 == 5'd0) ? '0 : regs[i_ra2];

endmodule

// File: hw/rv_core.sv
// ----------------------------------------------------------
// Core top with instruction fetch port in and store port out
// ----------------------------------------------------------
`timescale 1ns/1ns
module rv_core (
    input  logic                    i_clk,
    input  logic                    i_rst,
    output logic [rv_pkg::XLEN-1:0] o_pc,        // Fetch address
    input  logic [31:0]             i_instr,     // Fetched word, same cycle
    output logic                    o_mem_we,    // Store this cycle
    output logic [rv_pkg::XLEN-1:0] o_mem_addr,
    output logic [rv_pkg::XLEN-1:0] o_mem_wdata, // Lane-shifted store data
    output logic [3:0]              o_mem_be
);
    import rv_pkg::*;

    instr_u          instr;
    logic            memwrite;
    logic [2:0]      f3;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;

    ctrl_if cif ();

    assign instr = i_instr;

    controller u_controller (
        .i_instr    (instr),
        .cif        (cif.ctrl),
        .o_memwrite (memwrite),
        .o_f3       (f3)
    );

    datapath u_datapath (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_instr (instr),
        .cif     (cif.dp),
        .i_rdata (rdata),
        .o_pc    (o_pc),
        .o_addr  (o_mem_addr),
        .o_wdata (wdata)
    );

    dmem u_dmem (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_we         (memwrite),
        .i_f3         (f3),
        .i_addr       (o_mem_addr),
        .i_wdata      (wdata),
        .o_rdata      (rdata),
        .o_be         (o_mem_be),
        .o_wdata_lane (o_mem_wdata)
    );

    assign o_mem_we = memwrite && !i_rst;  // Quiet during reset

endmodule

// File: hw/rv_pkg.sv
// ----------------------------------------------------------
// Shared encodings for the RV32I subset core
// Opcodes, mux select codes, ALU codes and instruction views
// ----------------------------------------------------------
package rv_pkg;

    localparam int XLEN = 32;                 // Data and address width

    // Major opcodes
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    localparam logic [2:0] IMM_I = 3'd0;      // Immediate formats
    localparam logic [2:0] IMM_S = 3'd1;
    localparam logic [2:0] IMM_B = 3'd2;
    localparam logic [2:0] IMM_J = 3'd3;
    localparam logic [2:0] IMM_U = 3'd4;

    localparam logic [1:0] RES_ALU = 2'd0;    // Write-back source
    localparam logic [1:0] RES_MEM = 2'd1;
    localparam logic [1:0] RES_PC4 = 2'd2;

    localparam logic [1:0] ALUOP_ADD    = 2'b00; // Address calc, lui
    localparam logic [1:0] ALUOP_BRANCH = 2'b01; // Compare for branches
    localparam logic [1:0] ALUOP_FUNC   = 2'b10; // From funct3/funct7

    localparam logic [3:0] ALU_ADD   = 4'd0;
    localparam logic [3:0] ALU_SUB   = 4'd1;
    localparam logic [3:0] ALU_AND   = 4'd2;
    localparam logic [3:0] ALU_OR    = 4'd3;
    localparam logic [3:0] ALU_XOR   = 4'd4;
    localparam logic [3:0] ALU_SLT   = 4'd5;
    localparam logic [3:0] ALU_SLTU  = 4'd6;
    localparam logic [3:0] ALU_SLL   = 4'd7;
    localparam logic [3:0] ALU_SRL   = 4'd8;
    localparam logic [3:0] ALU_SRA   = 4'd9;
    localparam logic [3:0] ALU_PASSB = 4'd10; // Operand B straight through

    localparam logic [2:0] F3_SW = 3'b010;    // Word access size

    // One instruction word, seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] op;
        } r;
        struct packed {
            logic [11:0] imm11_0;
            logic [19:0] rest;
        } i;
        struct packed {
            logic [6:0]  imm11_5;
            logic [12:0] regs;
            logic [4:0]  imm4_0;
            logic [6:0]  op;
        } s;
        struct packed {
            logic        imm12;
            logic [5:0]  imm10_5;
            logic [12:0] regs;
            logic [3:0]  imm4_1;
            logic        imm11;
            logic [6:0]  op;
        } b;
        struct packed {
            logic [19:0] imm31_12;
            logic [11:0] rest;
        } u;
        struct packed {
            logic        imm20;
            logic [9:0]  imm10_1;
            logic        imm11;
            logic [7:0]  imm19_12;
            logic [11:0] rest;
        } j;
    } instr_u;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_rv_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_rv_core 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation binary returned status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" <<< "$out"; then
    exit 0
fi
exit 1

// File: verif/tb_program.svh
// ----------------------------------------------------------
// Test program, expected stores and PC trace for the core
// ----------------------------------------------------------
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_RTYPE};
endfunction

function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
    return {imm, rs1, f3, rd, op};  // Also loads
endfunction

function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], OP_STORE}; // Base is x0
endfunction

function automatic logic [31:0] btype_word(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic logic [31:0] jtype_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

// Appends a word; only executed words enter the PC trace
task automatic emit_instr(input logic [31:0] word, input int test, input bit runs);
    prog[prog_len] = word;
    if (runs) begin
        trace_pc[trace_len]   = 32'(prog_len * 4);
        trace_test[trace_len] = test;
        trace_len++;
    end
    prog_len++;
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be, input int test);
    exp_addr[store_cnt] = addr;
    exp_data[store_cnt] = data;
    exp_be[store_cnt]   = be;
    exp_test[store_cnt] = test;
    store_cnt++;
endtask

// Runs one instruction, then sw of its rd to a fixed address
task automatic store_result(input logic [31:0] word, input logic [4:0] rd,
                            input logic [11:0] addr, input logic [31:0] value, input int test);
    emit_instr(word, 1, 1'b1);
    emit_instr(stype_word(addr, rd, 3'b010), 1, 1'b1);
    expect_store({20'd0, addr}, value, 4'b1111, test);
endtask

task automatic emit_branch(input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [2:0] f3, input bit taken);
    emit_instr(btype_word(13'd8, rs2, rs1, f3), 5, 1'b1);
    if (taken) emit_instr(marker, 5, 1'b0);   // Must be skipped
    else       emit_instr(nop, 5, 1'b1);
endtask

task automatic build_program();
    logic [31:0] link;
    emit_instr(itype_word(12'd100, 5'd0, 3'b000, 5'd1, OP_ITYPE), 1, 1'b1); // x1 = 100
    emit_instr(itype_word(12'hFF9, 5'd0, 3'b000, 5'd2, OP_ITYPE), 1, 1'b1); // x2 = -7
    emit_instr({20'h12345, 5'd3, OP_LUI}, 1, 1'b1);
    emit_instr(itype_word(12'd3, 5'd0, 3'b000, 5'd12, OP_ITYPE), 1, 1'b1); // Shift 3
    store_result(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 12'd0, 32'h0000005D, 2);
    store_result(rtype_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd5), 5'd5, 12'd4, 32'h0000006B, 2);
    store_result(rtype_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd6), 5'd6, 12'd8, 32'h00000060, 2);
    store_result(rtype_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd7), 5'd7, 12'd12, 32'hFFFFFFFD, 2);
    store_result(rtype_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd8), 5'd8, 12'd16, 32'hFFFFFF9D, 2);
    store_result(rtype_word(7'h00, 5'd1, 5'd2, 3'b010, 5'd9), 5'd9, 12'd20, 32'h00000001, 2);
    store_result(rtype_word(7'h00, 5'd1, 5'd2, 3'b011, 5'd10), 5'd10, 12'd24, 32'h0, 2);
    store_result(rtype_word(7'h00, 5'd12, 5'd1, 3'b001, 5'd11), 5'd11, 12'd28, 32'h320, 2);
    store_result(rtype_word(7'h00, 5'd12, 5'd2, 3'b101, 5'd13), 5'd13, 12'd32, 32'h1FFFFFFF, 2);
    store_result(rtype_word(7'h20, 5'd12, 5'd2, 3'b101, 5'd14), 5'd14, 12'd36, 32'hFFFFFFFF, 2);
    emit_instr(stype_word(12'd40, 5'd3, 3'b010), 1, 1'b1);
    expect_store(32'd40, 32'h12345000, 4'b1111, 2);
    store_result(itype_word(12'h00F, 5'd1, 3'b100, 5'd15, OP_ITYPE), 5'd15, 12'd44,
                 32'h0000006B, 2);
    store_result(itype_word(12'h401, 5'd2, 3'b101, 5'd16, OP_ITYPE), 5'd16, 12'd48,
                 32'hFFFFFFFC, 2);
    store_result(itype_word(12'h000, 5'd2, 3'b010, 5'd17, OP_ITYPE), 5'd17, 12'd52,
                 32'h00000001, 2);
    store_result(itype_word(12'h0F0, 5'd2, 3'b111, 5'd18, OP_ITYPE), 5'd18, 12'd56,
                 32'h000000F0, 2);
    store_result(itype_word(12'h004, 5'd1, 3'b001, 5'd19, OP_ITYPE), 5'd19, 12'd100,
                 32'h00000640, 2);
    store_result(itype_word(12'h004, 5'd2, 3'b101, 5'd27, OP_ITYPE), 5'd27, 12'd104,
                 32'h0FFFFFFF, 2);
    store_result(itype_word(12'h801, 5'd1, 3'b110, 5'd30, OP_ITYPE), 5'd30, 12'd108,
                 32'hFFFFF865, 2);
    store_result(itype_word(12'hFFF, 5'd1, 3'b011, 5'd31, OP_ITYPE), 5'd31, 12'd112,
                 32'h00000001, 2);
    // Byte and halfword stores into word 0x40
    emit_instr(itype_word(12'hF94, 5'd0, 3'b000, 5'd20, OP_ITYPE), 1, 1'b1);
    emit_instr(stype_word(12'd64, 5'd1, 3'b000), 1, 1'b1);
    expect_store(32'd64, 32'h00000064, 4'b0001, 3);
    emit_instr(stype_word(12'd65, 5'd20, 3'b000), 1, 1'b1);
    expect_store(32'd65, 32'h00009400, 4'b0010, 3);
    emit_instr(stype_word(12'd66, 5'd20, 3'b001), 1, 1'b1);
    expect_store(32'd66, 32'hFF940000, 4'b1100, 3);
    // Word 0x40 now holds FF949464
    store_result(itype_word(12'd65, 5'd0, 3'b000, 5'd21, OP_LOAD), 5'd21, 12'd68,
                 32'hFFFFFF94, 4);
    store_result(itype_word(12'd65, 5'd0, 3'b100, 5'd22, OP_LOAD), 5'd22, 12'd72,
                 32'h00000094, 4);
    store_result(itype_word(12'd64, 5'd0, 3'b001, 5'd23, OP_LOAD), 5'd23, 12'd76,
                 32'hFFFF9464, 4);
    store_result(itype_word(12'd66, 5'd0, 3'b101, 5'd24, OP_LOAD), 5'd24, 12'd80,
                 32'h0000FF94, 4);
    store_result(itype_word(12'd64, 5'd0, 3'b010, 5'd25, OP_LOAD), 5'd25, 12'd84,
                 32'hFF949464, 4);
    store_result(itype_word(12'd64, 5'd0, 3'b000, 5'd26, OP_LOAD), 5'd26, 12'd88,
                 32'h00000064, 4);
    // Branches with x1 = 100 and x2 = -7
    emit_branch(5'd1, 5'd1, 3'b000, 1'b1);
    emit_branch(5'd1, 5'd2, 3'b000, 1'b0);
    emit_branch(5'd1, 5'd2, 3'b001, 1'b1);
    emit_branch(5'd1, 5'd1, 3'b001, 1'b0);
    emit_branch(5'd2, 5'd1, 3'b100, 1'b1);
    emit_branch(5'd1, 5'd2, 3'b100, 1'b0);
    emit_branch(5'd1, 5'd2, 3'b101, 1'b1);
    emit_branch(5'd2, 5'd1, 3'b101, 1'b0);
    emit_branch(5'd1, 5'd2, 3'b110, 1'b1);
    emit_branch(5'd2, 5'd1, 3'b110, 1'b0);
    emit_branch(5'd2, 5'd1, 3'b111, 1'b1);
    emit_branch(5'd1, 5'd2, 3'b111, 1'b0);
    link = 32'(prog_len * 4 + 4);
    emit_instr(jtype_word(21'd8, 5'd28), 5, 1'b1);
    emit_instr(marker, 5, 1'b0);
    emit_instr(stype_word(12'd92, 5'd28, 3'b010), 5, 1'b1);
    expect_store(32'd92, link, 4'b1111, 5);
    // Undefined opcode with rd = x29 must leave x29 alone
    emit_instr(itype_word(12'h055, 5'd0, 3'b000, 5'd29, OP_ITYPE), 6, 1'b1);
    emit_instr(32'hDEADBEFF, 6, 1'b1);
    emit_instr(stype_word(12'd96, 5'd29, 3'b010), 6, 1'b1);
    expect_store(32'd96, 32'h00000055, 4'b1111, 6);
    emit_instr(jtype_word(21'd0, 5'd0), 5, 1'b1);   // Self-loop
    for (int k = 0; k < 3; k++) begin
        trace_pc[trace_len]   = trace_pc[trace_len-1];
        trace_test[trace_len] = 5;
        trace_len++;
    end
endtask

`endif

// File: verif/tb_rv_core.sv
// ----------------------------------------------------------
// Testbench for rv_core running the program from its include
// Checks every PC and every store with assertions
// ----------------------------------------------------------
`timescale 1ns/1ns
module tb_rv_core;
    import rv_pkg::*;

    logic        clk;
    logic        rst;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_be;

    logic [31:0] prog [128];         // Instruction ROM
    int          prog_len = 0;
    logic [31:0] trace_pc [160];     // Expected PC per cycle
    int          trace_test [160];
    int          trace_len = 0;
    logic [31:0] exp_addr [32];
    logic [31:0] exp_data [32];
    logic [3:0]  exp_be [32];
    int          exp_test [32];
    int          store_cnt = 0;

    int          pc_idx = 0;         // Cycles checked so far
    int          store_idx = 0;      // Stores seen so far
    int          errs [7];           // Errors per test
    int          other_errs = 0;
    logic [31:0] exp_pc;
    int          pc_test_now;
    logic [31:0] lane_now;           // Enabled lanes of this store
    int          store_test_now;

    localparam logic [31:0] nop    = 32'h00000013;             // addi x0, x0, 0
    localparam logic [31:0] marker = 32'h3FF02E23;             // sw x31, 0x3fc(x0)

    `include "tb_program.svh"

    rv_core u_dut (
        .i_clk       (clk),
        .i_rst       (rst),
        .o_pc        (pc),
        .i_instr     (instr),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .o_mem_be    (mem_be)
    );

    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    // ROM answers in the same cycle
    assign instr          = (pc < 32'(prog_len * 4)) ? prog[pc[8:2]] : nop;
    assign exp_pc         = trace_pc[pc_idx < 160 ? pc_idx : 0];
    assign pc_test_now    = (pc_idx < trace_len) ? trace_test[pc_idx] : 5;
    assign lane_now       = lane_mask(mem_be);
    assign store_test_now = (store_idx < store_cnt) ? exp_test[store_idx] : pc_test_now;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                                  // 4 ns period
    end

    always @(posedge clk) begin
        if (!rst) begin
            pc_idx <= pc_idx + 1;
            if (mem_we) store_idx <= store_idx + 1;
        end
    end

    a_pc_trace: assert property (@(posedge clk) disable iff (rst)
        (pc_idx < trace_len) |-> (pc == exp_pc))
        else begin
            errs[$sampled(pc_test_now)]++;
            $display("** Error @%0t: pc %h, expected %h", $time, $sampled(pc),
                     $sampled(exp_pc));
        end

    a_store_expected: assert property (@(posedge clk) disable iff (rst)
        mem_we |-> (store_idx < store_cnt))
        else begin
            errs[$sampled(pc_test_now)]++;
            $display("** Error @%0t: unexpected store to %h at pc %h", $time,
                     $sampled(mem_addr), $sampled(pc));
        end

    a_store_value: assert property (@(posedge clk) disable iff (rst)
        (mem_we && store_idx < store_cnt) |->
            (mem_addr == exp_addr[store_idx] && mem_be == exp_be[store_idx] &&
             (mem_wdata & lane_now) == (exp_data[store_idx] & lane_now)))
        else begin
            errs[$sampled(store_test_now)]++;
            $display("** Error @%0t: store %h be %b data %h, expected %h be %b data %h",
                     $time, $sampled(mem_addr), $sampled(mem_be), $sampled(mem_wdata),
                     exp_addr[$sampled(store_idx)], exp_be[$sampled(store_idx)],
                     exp_data[$sampled(store_idx)]);
        end

    initial begin
        #1;
        #((16 + trace_len) * 4 * 4);
        $display("Timeout: the program never reached the end of its PC trace");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        string names [7];
        int    passed;
        int    failed;
        names = '{"", "pc sequence", "alu results", "byte/half stores",
                  "load extension", "branches and jal", "undefined opcode"};
        passed = 0;
        failed = 0;
        for (int t = 0; t < 7; t++) errs[t] = 0;
        rst = 1'b1;
        build_program();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        while (pc_idx < trace_len) @(posedge clk);
        @(posedge clk);
        if (store_idx != store_cnt) begin
            other_errs++;
            $display("Store count wrong: saw %0d stores, expected %0d", store_idx, store_cnt);
        end
        for (int t = 1; t < 7; t++) begin
            $display("Test %0d %s: %s, %0d error(s)", t, names[t],
                     (errs[t] == 0) ? "passed" : "failed", errs[t]);
            if (errs[t] == 0) passed++;
            else              failed++;
        end
        $display("Tests: %0d passed, %0d failed, %0d other error(s)", passed, failed,
                 other_errs);
        if (failed == 0 && other_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
